// ==== l2_pkg.sv ====
package l2_pkg;

    ////////////////////
    // widths
    ////////////////////

    parameter int ADDR_WIDTH      = 28;  // word address
    parameter int WORD_WIDTH      = 32;
    parameter int WORDS_PER_BLOCK = 4;
    parameter int OFFSET_WIDTH    = 2;   // word select within a block
    parameter int NUM_WAYS        = 4;
    parameter int WAY_WIDTH       = 2;
    parameter int PLRU_WIDTH      = 3;   // tree bits per set

    ////////////////////
    // address fields
    ////////////////////

    // offset sits at the bottom, index right above it, tag takes the rest
    parameter int OFFSET_LSB = 0;
    parameter int INDEX_LSB  = OFFSET_LSB + OFFSET_WIDTH;

    ////////////////////
    // vector types
    ////////////////////

    typedef logic [ADDR_WIDTH-1:0]                 addr_t;
    typedef logic [WORD_WIDTH-1:0]                 word_t;
    typedef logic [WORD_WIDTH*WORDS_PER_BLOCK-1:0] block_t;   // word k at bit 32k
    typedef logic [WAY_WIDTH-1:0]                  way_t;
    typedef logic [OFFSET_WIDTH-1:0]               offset_t;
    typedef logic [PLRU_WIDTH-1:0]                 plru_t;

endpackage

// ==== l2_req_if.sv ====
`timescale 1ns/1ns

interface l2_req_if;
    import l2_pkg::*;

    logic  valid;   // one-cycle strobe without back-pressure
    logic  write;
    logic  to_dc;   // 0 for the instruction side
    addr_t addr;
    word_t wdata;

    modport src (
        output valid, write, to_dc, addr, wdata
    );

    modport dst (
        input valid, write, to_dc, addr, wdata
    );
endinterface

// ==== l2_lookup_if.sv ====
`timescale 1ns/1ns

interface l2_lookup_if #(
    parameter int INDEX_WIDTH = 4
);
    import l2_pkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    addr_t                lookup_addr;
    logic                 update;       // touch pseudo-LRU
    way_t                 update_way;   // way for update, dirty and refill
    logic                 set_dirty;
    logic                 refill;
    logic [TAG_WIDTH-1:0] refill_tag;
    logic                 hit;
    way_t                 hit_way;
    way_t                 victim_way;
    logic                 victim_dirty_valid;
    logic [TAG_WIDTH-1:0] victim_tag;

    modport ctrl (
        output lookup_addr, update, update_way, set_dirty, refill, refill_tag,
        input  hit, hit_way, victim_way, victim_dirty_valid, victim_tag
    );

    modport store (
        input  lookup_addr, update, update_way, set_dirty, refill, refill_tag,
        output hit, hit_way, victim_way, victim_dirty_valid, victim_tag
    );
endinterface

// ==== l2_req_arbiter.sv ====
`timescale 1ns/1ns

module l2_req_arbiter (
    input  logic           clk,
    input  logic           reset,
    input  logic           ic_req,
    input  l2_pkg::addr_t  ic_addr,
    input  logic           dc_req,
    input  logic           dc_write,
    input  l2_pkg::addr_t  dc_addr,
    input  l2_pkg::word_t  dc_wdata,
    input  logic           ctrl_idle,
    output logic           busy,
    l2_req_if.src          req
);

    logic accept;

    // requests only count while nothing is in flight
    assign accept = !busy && (ic_req || dc_req);

    // strobe cycle plus every non-idle controller cycle
    assign busy = req.valid || !ctrl_idle;

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= accept;
        end
    end

    ////////////////////
    // request payload
    ////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            req.to_dc <= !ic_req;                       // instruction side wins
            req.write <= !ic_req && dc_write;           // ic is read only
            req.addr  <= ic_req ? ic_addr : dc_addr;
            req.wdata <= dc_wdata;
        end
    end

endmodule

// ==== l2_tag_store.sv ====
`timescale 1ns/1ns

module l2_tag_store #(
    parameter int INDEX_WIDTH = 4
) (
    input logic        clk,
    input logic        reset,
    l2_lookup_if.store lookup
);
    import l2_pkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_WIDTH;
    localparam int NUM_SETS  = 1 << INDEX_WIDTH;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    tag_t                tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0] valid_mem [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_mem [NUM_SETS];
    plru_t               plru_mem [NUM_SETS];

    logic [INDEX_WIDTH-1:0] index;
    tag_t                   tag;
    logic [NUM_WAYS-1:0]    way_valid;
    logic [NUM_WAYS-1:0]    way_dirty;
    logic [NUM_WAYS-1:0]    way_match;
    plru_t                  plru;
    plru_t                  plru_next;
    way_t                   victim;

    assign index     = lookup.lookup_addr[INDEX_LSB +: INDEX_WIDTH];
    assign tag       = lookup.lookup_addr[TAG_LSB +: TAG_WIDTH];
    assign way_valid = valid_mem[index];
    assign way_dirty = dirty_mem[index];
    assign plru      = plru_mem[index];

    ////////////////////
    // tag compare
    ////////////////////

    always_comb begin
        lookup.hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            way_match[w] = way_valid[w] && (tag_mem[w][index] == tag);
            if (way_match[w]) begin
                lookup.hit_way = way_t'(w);
            end
        end
    end

    assign lookup.hit = |way_match;

    ////////////////////
    // victim choice
    ////////////////////

    always_comb begin
        victim = '0;
        if (&way_valid) begin
            if (!plru[0]) begin
                victim = plru[1] ? way_t'(1) : way_t'(0);   // left pair
            end else begin
                victim = plru[2] ? way_t'(3) : way_t'(2);   // right pair
            end
        end else begin
            for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                if (!way_valid[w]) begin
                    victim = way_t'(w);                     // lowest invalid wins
                end
            end
        end
    end

    assign lookup.victim_way         = victim;
    assign lookup.victim_dirty_valid = way_valid[victim] && way_dirty[victim];
    assign lookup.victim_tag         = tag_mem[victim][index];

    // point the tree away from the way just used
    always_comb begin
        plru_next = plru;
        case (lookup.update_way)
            2'd0:    plru_next = {plru[2], 1'b1, 1'b1};
            2'd1:    plru_next = {plru[2], 1'b0, 1'b1};
            2'd2:    plru_next = {1'b1, plru[1], 1'b0};
            default: plru_next = {1'b0, plru[1], 1'b0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                plru_mem[s]  <= '0;
            end
        end else begin
            if (lookup.update) begin
                plru_mem[index] <= plru_next;
            end
            if (lookup.set_dirty) begin
                dirty_mem[index][lookup.update_way] <= 1'b1;
            end
            if (lookup.refill) begin
                valid_mem[index][lookup.update_way] <= 1'b1;
                dirty_mem[index][lookup.update_way] <= 1'b0;   // fresh from memory
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.refill) begin
            tag_mem[lookup.update_way][index] <= lookup.refill_tag;
        end
    end

endmodule

// ==== l2_data_store.sv ====
`timescale 1ns/1ns

module l2_data_store #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                   clk,
    input  logic [INDEX_WIDTH-1:0] index,
    input  l2_pkg::way_t           rd_way,
    output l2_pkg::block_t         rd_block,
    input  logic                   wr_word_en,
    input  logic                   wr_block_en,
    input  l2_pkg::way_t           wr_way,
    input  l2_pkg::offset_t        offset,
    input  l2_pkg::word_t          wr_word,
    input  l2_pkg::block_t         wr_block
);
    import l2_pkg::*;

    localparam int NUM_SETS = 1 << INDEX_WIDTH;

    block_t data_mem [NUM_WAYS][NUM_SETS];
    block_t merged;   // current block with the new word dropped in

    // read side is combinational
    assign rd_block = data_mem[rd_way][index];

    ////////////////////
    // word merge
    ////////////////////

    always_comb begin
        merged = data_mem[wr_way][index];
        for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
            if (offset == offset_t'(k)) begin
                merged[k*WORD_WIDTH +: WORD_WIDTH] = wr_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_block_en) begin
            data_mem[wr_way][index] <= wr_block;   // refill
        end else if (wr_word_en) begin
            data_mem[wr_way][index] <= merged;
        end
    end

endmodule

// ==== l2_cache_ctrl.sv ====
`timescale 1ns/1ns

module l2_cache_ctrl #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    l2_req_if.dst                  req,
    l2_lookup_if.ctrl              lookup,
    output logic [INDEX_WIDTH-1:0] ds_index,
    output l2_pkg::way_t           ds_rd_way,
    input  l2_pkg::block_t         ds_rd_block,
    output logic                   ds_wr_word_en,
    output logic                   ds_wr_block_en,
    output l2_pkg::way_t           ds_wr_way,
    output l2_pkg::offset_t        ds_offset,
    output l2_pkg::word_t          ds_wr_word,
    output l2_pkg::block_t         ds_wr_block,
    output logic                   ctrl_idle,
    input  logic                   mem_done,
    input  l2_pkg::block_t         mem_rd_data,
    output logic                   rsp_valid,
    output logic                   rsp_to_dc,
    output l2_pkg::word_t          rsp_data,
    output logic                   mem_fetch,
    output l2_pkg::addr_t          mem_fetch_addr,
    output logic                   mem_wb,
    output l2_pkg::addr_t          mem_wb_addr,
    output l2_pkg::block_t         mem_wb_data
);
    import l2_pkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_WIDTH;

    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef enum logic [1:0] {IDLE, MISS_WAIT, RELOOKUP} ctrl_state_t;

    ctrl_state_t state;
    logic        pend_write, pend_to_dc;   // request held across a miss
    addr_t       pend_addr;
    word_t       pend_wdata;
    way_t        pend_way;                 // victim picked at miss time

    logic                   active, do_hit, do_miss, do_refill;
    logic                   cur_write, cur_to_dc;
    addr_t                  cur_addr;
    word_t                  cur_wdata, rd_word;
    offset_t                cur_offset;
    logic [INDEX_WIDTH-1:0] cur_index;
    tag_t                   cur_tag;

    ////////////////////
    // lookup source
    ////////////////////

    always_comb begin
        if (state == IDLE) begin
            active    = req.valid;
            cur_write = req.write;
            cur_to_dc = req.to_dc;
            cur_addr  = req.addr;
            cur_wdata = req.wdata;
        end else begin
            active    = (state == RELOOKUP);   // replay the latched request
            cur_write = pend_write;
            cur_to_dc = pend_to_dc;
            cur_addr  = pend_addr;
            cur_wdata = pend_wdata;
        end
    end

    assign cur_offset = cur_addr[OFFSET_LSB +: OFFSET_WIDTH];
    assign cur_index  = cur_addr[INDEX_LSB +: INDEX_WIDTH];
    assign cur_tag    = cur_addr[TAG_LSB +: TAG_WIDTH];
    assign do_hit     = active && lookup.hit;
    assign do_miss    = active && !lookup.hit;
    assign do_refill  = (state == MISS_WAIT) && mem_done;
    assign ctrl_idle  = (state == IDLE);

    assign lookup.lookup_addr = cur_addr;
    assign lookup.update      = do_hit;
    assign lookup.update_way  = (state == MISS_WAIT) ? pend_way : lookup.hit_way;
    assign lookup.set_dirty   = do_hit && cur_write;
    assign lookup.refill      = do_refill;
    assign lookup.refill_tag  = cur_tag;

    assign ds_index       = cur_index;
    assign ds_rd_way      = lookup.hit ? lookup.hit_way : lookup.victim_way;
    assign ds_wr_word_en  = do_hit && cur_write;
    assign ds_wr_block_en = do_refill;
    assign ds_wr_way      = lookup.update_way;
    assign ds_offset      = cur_offset;
    assign ds_wr_word     = cur_wdata;
    assign ds_wr_block    = mem_rd_data;
    assign rd_word        = ds_rd_block[cur_offset*WORD_WIDTH +: WORD_WIDTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            rsp_valid <= 1'b0;
            mem_fetch <= 1'b0;
            mem_wb    <= 1'b0;
        end else begin
            rsp_valid <= do_hit;
            mem_fetch <= do_miss;
            mem_wb    <= do_miss && lookup.victim_dirty_valid;   // dirty victim goes out too
            case (state)
                IDLE, RELOOKUP: state <= do_miss ? MISS_WAIT : IDLE;
                MISS_WAIT:      state <= mem_done ? RELOOKUP : MISS_WAIT;
                default:        state <= IDLE;
            endcase
        end
    end

    ////////////////////
    // response and memory payload
    ////////////////////

    always_ff @(posedge clk) begin
        if (do_hit) begin
            rsp_to_dc <= cur_to_dc;
            rsp_data  <= cur_write ? cur_wdata : rd_word;   // echo written word
        end
        if (do_miss) begin
            pend_write     <= cur_write;
            pend_to_dc     <= cur_to_dc;
            pend_addr      <= cur_addr;
            pend_wdata     <= cur_wdata;
            pend_way       <= lookup.victim_way;
            mem_fetch_addr <= {cur_tag, cur_index, {OFFSET_WIDTH{1'b0}}};
            mem_wb_addr    <= {lookup.victim_tag, cur_index, {OFFSET_WIDTH{1'b0}}};
            mem_wb_data    <= ds_rd_block;
        end
    end

endmodule

// ==== l2_cache.sv ====
`timescale 1ns/1ns

module l2_cache #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           ic_req,
    input  l2_pkg::addr_t  ic_addr,
    input  logic           dc_req,
    input  logic           dc_write,
    input  l2_pkg::addr_t  dc_addr,
    input  l2_pkg::word_t  dc_wdata,
    input  logic           mem_done,
    input  l2_pkg::block_t mem_rd_data,
    output logic           busy,
    output logic           rsp_valid,
    output logic           rsp_to_dc,
    output l2_pkg::word_t  rsp_data,
    output logic           mem_fetch,
    output l2_pkg::addr_t  mem_fetch_addr,
    output logic           mem_wb,
    output l2_pkg::addr_t  mem_wb_addr,
    output l2_pkg::block_t mem_wb_data
);
    import l2_pkg::*;

    logic                   ctrl_idle;
    logic [INDEX_WIDTH-1:0] ds_index;
    way_t                   ds_rd_way, ds_wr_way;
    block_t                 ds_rd_block, ds_wr_block;
    logic                   ds_wr_word_en, ds_wr_block_en;
    offset_t                ds_offset;
    word_t                  ds_wr_word;

    l2_req_if                                   req_bus ();
    l2_lookup_if #(.INDEX_WIDTH(INDEX_WIDTH))   lookup_bus ();

    ////////////////////
    // blocks
    ////////////////////

    l2_req_arbiter arb0 (
        .clk(clk), .reset(reset),
        .ic_req(ic_req), .ic_addr(ic_addr),
        .dc_req(dc_req), .dc_write(dc_write), .dc_addr(dc_addr), .dc_wdata(dc_wdata),
        .ctrl_idle(ctrl_idle), .busy(busy), .req(req_bus.src)
    );

    l2_tag_store #(.INDEX_WIDTH(INDEX_WIDTH)) tags0 (
        .clk(clk), .reset(reset), .lookup(lookup_bus.store)
    );

    l2_data_store #(.INDEX_WIDTH(INDEX_WIDTH)) data0 (
        .clk(clk), .index(ds_index), .rd_way(ds_rd_way), .rd_block(ds_rd_block),
        .wr_word_en(ds_wr_word_en), .wr_block_en(ds_wr_block_en), .wr_way(ds_wr_way),
        .offset(ds_offset), .wr_word(ds_wr_word), .wr_block(ds_wr_block)
    );

    l2_cache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) ctrl0 (
        .clk(clk), .reset(reset), .req(req_bus.dst), .lookup(lookup_bus.ctrl),
        .ds_index(ds_index), .ds_rd_way(ds_rd_way), .ds_rd_block(ds_rd_block),
        .ds_wr_word_en(ds_wr_word_en), .ds_wr_block_en(ds_wr_block_en),
        .ds_wr_way(ds_wr_way), .ds_offset(ds_offset), .ds_wr_word(ds_wr_word),
        .ds_wr_block(ds_wr_block), .ctrl_idle(ctrl_idle),
        .mem_done(mem_done), .mem_rd_data(mem_rd_data),
        .rsp_valid(rsp_valid), .rsp_to_dc(rsp_to_dc), .rsp_data(rsp_data),
        .mem_fetch(mem_fetch), .mem_fetch_addr(mem_fetch_addr),
        .mem_wb(mem_wb), .mem_wb_addr(mem_wb_addr), .mem_wb_data(mem_wb_data)
    );

endmodule

// ==== l2_cache_assertions.sv ====
`timescale 1ns/1ns

module l2_cache_assertions (
    input logic clk,
    input logic reset,
    input logic ic_req,
    input logic dc_req,
    input logic busy,
    input logic rsp_valid,
    input logic mem_fetch,
    input logic mem_wb,
    input logic mem_done
);

    int   fail_count = 0;
    logic mem_pending;   // fetch out and done not back yet

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_pending <= 1'b0;
        end else if (mem_fetch) begin
            mem_pending <= 1'b1;
        end else if (mem_done) begin
            mem_pending <= 1'b0;
        end
    end

    rsp_one_cycle: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |=> !rsp_valid)
        else begin
            fail_count++;
            $error("rsp_valid high for more than one cycle");
        end

    wb_with_fetch: assert property (@(posedge clk) disable iff (reset)
        mem_wb |-> mem_fetch)
        else begin
            fail_count++;
            $error("mem_wb without mem_fetch");
        end

    no_rsp_in_miss: assert property (@(posedge clk) disable iff (reset)
        mem_pending |-> !rsp_valid)
        else begin
            fail_count++;
            $error("rsp_valid while waiting for memory");
        end

    busy_after_accept: assert property (@(posedge clk) disable iff (reset)
        (!busy && (ic_req || dc_req)) |=> busy)
        else begin
            fail_count++;
            $error("busy low after an accepted request");
        end

endmodule

bind l2_cache l2_cache_assertions chk0 (
    .clk(clk), .reset(reset), .ic_req(ic_req), .dc_req(dc_req), .busy(busy),
    .rsp_valid(rsp_valid), .mem_fetch(mem_fetch), .mem_wb(mem_wb), .mem_done(mem_done)
);

// ==== tb_l2_cache.sv ====
`timescale 1ns/1ns

module tb_l2_cache;
    import l2_pkg::*;

    typedef struct packed {
        logic  ic;
        logic  dc;
        logic  write;
        logic  busy_req;    // extra dc read while busy
        addr_t addr;
        word_t wdata;
        word_t exp_word;
        logic  exp_fetch;
        logic  exp_wb;
        addr_t wb_addr;
    } entry_t;

    logic   clk, reset, ic_req, dc_req, dc_write, mem_done;
    addr_t  ic_addr, dc_addr;
    word_t  dc_wdata, rsp_data;
    block_t mem_rd_data, mem_wb_data;
    logic   busy, rsp_valid, rsp_to_dc, mem_fetch, mem_wb;
    addr_t  mem_fetch_addr, mem_wb_addr;

    entry_t entries[$];
    string  names[$];
    word_t  written[addr_t];   // words stored by dc writes
    int     seed = 88;
    int     errors = 0;
    int     rsp_count, fetch_count, wb_count;
    word_t  rsp_data_seen;
    logic   rsp_to_dc_seen;
    addr_t  fetch_addr_seen;
    addr_t  wb_addr_seen;
    block_t wb_data_seen;

    l2_cache #(.INDEX_WIDTH(4)) dut0 (
        .clk(clk), .reset(reset),
        .ic_req(ic_req), .ic_addr(ic_addr),
        .dc_req(dc_req), .dc_write(dc_write), .dc_addr(dc_addr), .dc_wdata(dc_wdata),
        .mem_done(mem_done), .mem_rd_data(mem_rd_data), .busy(busy),
        .rsp_valid(rsp_valid), .rsp_to_dc(rsp_to_dc), .rsp_data(rsp_data),
        .mem_fetch(mem_fetch), .mem_fetch_addr(mem_fetch_addr),
        .mem_wb(mem_wb), .mem_wb_addr(mem_wb_addr), .mem_wb_data(mem_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory contents are the word address xor a fixed pattern
    function automatic block_t block_pattern(input addr_t base);
        block_t b;
        for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
            b[k*WORD_WIDTH +: WORD_WIDTH] = {4'b0, base + addr_t'(k)} ^ 32'h5a5a_0000;
        end
        return b;
    endfunction

    // what a dirty victim should carry back
    function automatic block_t expected_block(input addr_t base);
        block_t b;
        addr_t  a;
        b = block_pattern(base);
        for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
            a = base + addr_t'(k);
            if (written.exists(a)) begin
                b[k*WORD_WIDTH +: WORD_WIDTH] = written[a];
            end
        end
        return b;
    endfunction

    task automatic add_entry(input string name, input logic ic, dc, write, busy_req,
                             input addr_t addr, input word_t wdata, exp_word,
                             input logic exp_fetch, exp_wb, input addr_t wb_addr);
        names.push_back(name);
        entries.push_back(entry_t'{ic, dc, write, busy_req, addr, wdata, exp_word,
                                   exp_fetch, exp_wb, wb_addr});
    endtask

    ////////////////////
    // stimulus table
    ////////////////////

    task automatic build_table();
        add_entry("read_miss",      1, 0, 0, 0, 28'h45,  32'h0, 32'h5a5a0045, 1, 0, 28'h0);
        add_entry("read_hit",       1, 0, 0, 0, 28'h47,  32'h0, 32'h5a5a0047, 0, 0, 28'h0);
        add_entry("write_hit",      0, 1, 1, 0, 28'h46,  32'hcafe0001, 32'hcafe0001, 0, 0, 28'h0);
        add_entry("read_written",   0, 1, 0, 0, 28'h46,  32'h0, 32'hcafe0001, 0, 0, 28'h0);
        add_entry("plru_fill_t1",   0, 1, 0, 0, 28'h48,  32'h0, 32'h5a5a0048, 1, 0, 28'h0);
        add_entry("plru_fill_t2",   0, 1, 0, 0, 28'h88,  32'h0, 32'h5a5a0088, 1, 0, 28'h0);
        add_entry("plru_fill_t3",   0, 1, 0, 0, 28'hc8,  32'h0, 32'h5a5a00c8, 1, 0, 28'h0);
        add_entry("plru_fill_t4",   0, 1, 0, 0, 28'h108, 32'h0, 32'h5a5a0108, 1, 0, 28'h0);
        add_entry("plru_evict_w0",  0, 1, 0, 0, 28'h148, 32'h0, 32'h5a5a0148, 1, 0, 28'h0);
        add_entry("reread_t1_miss", 0, 1, 0, 0, 28'h48,  32'h0, 32'h5a5a0048, 1, 0, 28'h0);
        add_entry("t2_still_hit",   0, 1, 0, 0, 28'h89,  32'h0, 32'h5a5a0089, 0, 0, 28'h0);
        add_entry("t3_miss_clean",  0, 1, 0, 0, 28'hc8,  32'h0, 32'h5a5a00c8, 1, 0, 28'h0);
        add_entry("fill_idx1_t2",   1, 0, 0, 0, 28'h84,  32'h0, 32'h5a5a0084, 1, 0, 28'h0);
        add_entry("fill_idx1_t3",   1, 0, 0, 0, 28'hc4,  32'h0, 32'h5a5a00c4, 1, 0, 28'h0);
        add_entry("fill_idx1_t4",   1, 0, 0, 0, 28'h104, 32'h0, 32'h5a5a0104, 1, 0, 28'h0);
        add_entry("evict_dirty",    1, 0, 0, 0, 28'h144, 32'h0, 32'h5a5a0144, 1, 1, 28'h44);
        add_entry("arb_ic_wins",    1, 1, 1, 1, 28'h145, 32'hdead0005, 32'h5a5a0145, 0, 0, 28'h0);
        add_entry("arb_dc_lost",    0, 1, 0, 0, 28'h145, 32'h0, 32'h5a5a0145, 0, 0, 28'h0);
    endtask

    task automatic run_entry(input string name, input entry_t e);
        int    rsp0, fetch0, wb0;
        addr_t block_addr;
        block_addr = {e.addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
        rsp0   = rsp_count;
        fetch0 = fetch_count;
        wb0    = wb_count;
        #1;
        ic_req   = e.ic;
        ic_addr  = e.addr;
        dc_req   = e.dc;
        dc_write = e.write;
        dc_addr  = e.addr;
        dc_wdata = e.wdata;
        @(posedge clk);
        #1;
        if (e.busy_req) begin
            ic_req   = 1'b0;       // dc read lands while busy is high
            dc_req   = 1'b1;
            dc_write = 1'b0;
            @(posedge clk);
            #1;
        end
        ic_req   = 1'b0;
        dc_req   = 1'b0;
        dc_write = 1'b0;
        while (rsp_count == rsp0) @(posedge clk);
        repeat (3) @(posedge clk);   // room for a stray second response
        if (rsp_count - rsp0 != 1) begin
            $display("[ERROR] %s: responses expected 1, got %0d", name, rsp_count - rsp0);
            errors++;
        end
        if (rsp_data_seen !== e.exp_word) begin
            $display("[ERROR] %s: rsp_data expected %h, got %h", name, e.exp_word, rsp_data_seen);
            errors++;
        end
        if (rsp_to_dc_seen !== !e.ic) begin
            $display("[ERROR] %s: rsp_to_dc expected %b, got %b", name, !e.ic, rsp_to_dc_seen);
            errors++;
        end
        if (fetch_count - fetch0 != int'(e.exp_fetch)) begin
            $display("[ERROR] %s: fetches expected %0d, got %0d", name, e.exp_fetch,
                     fetch_count - fetch0);
            errors++;
        end
        if (e.exp_fetch && fetch_addr_seen !== block_addr) begin
            $display("[ERROR] %s: mem_fetch_addr expected %h, got %h", name, block_addr,
                     fetch_addr_seen);
            errors++;
        end
        if (wb_count - wb0 != int'(e.exp_wb)) begin
            $display("[ERROR] %s: writebacks expected %0d, got %0d", name, e.exp_wb,
                     wb_count - wb0);
            errors++;
        end
        if (e.exp_wb && wb_addr_seen !== e.wb_addr) begin
            $display("[ERROR] %s: mem_wb_addr expected %h, got %h", name, e.wb_addr, wb_addr_seen);
            errors++;
        end
        if (e.exp_wb && wb_data_seen !== expected_block(e.wb_addr)) begin
            $display("[ERROR] %s: mem_wb_data expected %h, got %h", name,
                     expected_block(e.wb_addr), wb_data_seen);
            errors++;
        end
        if (e.dc && !e.ic && e.write) begin
            written[e.addr] = e.wdata;
        end
    endtask

    ////////////////////
    // monitors
    ////////////////////

    initial begin
        rsp_count   = 0;
        fetch_count = 0;
        forever begin
            @(negedge clk);
            if (rsp_valid) begin
                rsp_count++;
                rsp_data_seen  = rsp_data;
                rsp_to_dc_seen = rsp_to_dc;
            end
            if (mem_fetch) begin
                fetch_count++;
                fetch_addr_seen = mem_fetch_addr;
            end
        end
    end

    // memory model with one fetch in flight
    initial begin
        int    delay;
        addr_t fetch_addr;
        mem_done    = 1'b0;
        mem_rd_data = '0;
        wb_count    = 0;
        forever begin
            @(negedge clk);
            if (mem_fetch) begin
                fetch_addr = mem_fetch_addr;
                if (mem_wb) begin
                    wb_count++;
                    wb_addr_seen = mem_wb_addr;
                    wb_data_seen = mem_wb_data;
                end
                delay = 2 + int'($unsigned($random(seed)) % 8);   // 2 to 9 cycles
                repeat (delay) @(posedge clk);
                #1;
                mem_done    = 1'b1;
                mem_rd_data = block_pattern(fetch_addr);
                @(posedge clk);
                #1;
                mem_done = 1'b0;
            end
        end
    end

    initial begin
        int cycle_count;
        int limit;
        @(negedge reset);
        limit       = entries.size() * 20;
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        ic_req   = 1'b0;
        ic_addr  = '0;
        dc_req   = 1'b0;
        dc_write = 1'b0;
        dc_addr  = '0;
        dc_wdata = '0;
        build_table();
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        foreach (entries[i]) begin
            run_entry(names[i], entries[i]);
        end
        $display("done: %0d entries, %0d check errors, %0d assertion failures",
                 entries.size(), errors, dut0.chk0.fail_count);
        if (errors + dut0.chk0.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== l2_cache.f ====
l2_pkg.sv
l2_req_if.sv
l2_lookup_if.sv
l2_req_arbiter.sv
l2_tag_store.sv
l2_data_store.sv
l2_cache_ctrl.sv
l2_cache.sv
l2_cache_assertions.sv
tb_l2_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the l2_cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_l2_cache \
    -f l2_cache.f -o sim_l2_cache
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/sim_l2_cache +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
